/* include/x_buffer_config.svh */
/*
 * Operand-X transpose buffer configuration.
 * Element width and tile geometry. Tile sizes are powers of two.
 */

`ifndef X_BUFFER_CONFIG_SVH
`define X_BUFFER_CONFIG_SVH

// Bits per element.
`define X_WORD_SIZE 32

// Rows and columns of a full tile.
`define X_ROWS 4
`define X_COLS 8

`endif

/* source/x_buffer_pkg.sv */
/*
 * Operand-X transpose buffer types.
 * Element, row and column vectors, indices and the tile size descriptor.
 */

`include "x_buffer_config.svh"

package x_buffer_pkg;

  localparam int unsigned WORD_SIZE = `X_WORD_SIZE;
  localparam int unsigned NUM_ROWS  = `X_ROWS;
  localparam int unsigned NUM_COLS  = `X_COLS;
  localparam int unsigned ROW_AW    = $clog2(NUM_ROWS);
  localparam int unsigned COL_AW    = $clog2(NUM_COLS);

  typedef logic [WORD_SIZE-1:0]     x_word_t;
  typedef x_word_t [NUM_COLS-1:0]   x_row_t;  // One tile row, word 0 in the low slot.
  typedef x_word_t [NUM_ROWS-1:0]   x_col_t;  // One tile column, row 0 in the low slot.
  typedef logic [ROW_AW-1:0]        x_row_addr_t;
  typedef logic [COL_AW-1:0]        x_col_addr_t;

  // Real size of the tile, counts run from 1 up to the full size.
  typedef struct packed {
    logic [ROW_AW:0] n_rows;
    logic [COL_AW:0] n_cols;
  } x_tile_cfg_t;

endpackage : x_buffer_pkg

/* source/x_row_packer.sv */
/*
 * Operand-X row packer.
 * Gathers serial input words into one row vector, wrapping at the tile's
 * real width so that the unused slots stay zero, and emits each finished
 * row as a registered vector with a one-cycle strobe.
 */

`timescale 1ns/10ps

module x_row_packer (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      clear_i,
  input  logic                      load_en_i,
  input  x_buffer_pkg::x_tile_cfg_t cfg_i,
  input  logic                      word_valid_i,
  input  x_buffer_pkg::x_word_t     word_i,
  output logic                      row_valid_o,
  output x_buffer_pkg::x_row_t      row_o
);
  import x_buffer_pkg::*;

  x_col_addr_t     slot_q;
  x_row_t          slots_q;
  x_row_t          slots_next;
  x_row_t          row_q;
  logic            row_valid_q;
  logic            take_word;
  logic            last_slot;
  logic [COL_AW:0] last_col;

  assign take_word = load_en_i & word_valid_i;
  assign last_col  = cfg_i.n_cols - 1'b1;
  assign last_slot = ({1'b0, slot_q} == last_col);

  // The row as it stands once the current word is placed.
  always_comb begin
    slots_next         = slots_q;
    slots_next[slot_q] = word_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slot_q      <= '0;
      row_valid_q <= 1'b0;
    end else if (clear_i) begin
      slot_q      <= '0;
      row_valid_q <= 1'b0;
    end else begin
      row_valid_q <= take_word & last_slot;
      if (take_word) begin
        slot_q <= last_slot ? '0 : slot_q + 1'b1;
      end
    end
  end

  // Slots restart from zero after every row, which pads short rows.
  always_ff @(posedge clk_i) begin
    if (clear_i) begin
      slots_q <= '0;
    end else if (take_word) begin
      slots_q <= last_slot ? '0 : slots_next;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take_word && last_slot) begin
      row_q <= slots_next;
    end
  end

  assign row_valid_o = row_valid_q;
  assign row_o       = row_q;

endmodule : x_row_packer

/* source/x_transpose_scm.sv */
/*
 * Operand-X transpose memory.
 * Flip-flop array written one row at a time and read one column at a time
 * through a registered column address, which yields the transposed tile.
 */

`timescale 1ns/10ps

module x_transpose_scm (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      clear_i,
  input  logic                      write_en_i,
  input  x_buffer_pkg::x_row_addr_t write_addr_i,
  input  x_buffer_pkg::x_row_t      wdata_i,
  input  logic                      read_en_i,
  input  x_buffer_pkg::x_col_addr_t read_addr_i,
  output x_buffer_pkg::x_col_t      rdata_o
);
  import x_buffer_pkg::*;

  x_row_t [NUM_ROWS-1:0] buffer_q;
  x_col_addr_t           read_addr_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      read_addr_q <= '0;
    end else if (clear_i) begin
      read_addr_q <= '0;
    end else if (read_en_i) begin
      read_addr_q <= read_addr_i;
    end
  end

  // Clearing the whole array makes rows the tile never writes read as zero.
  for (genvar r = 0; r < NUM_ROWS; r++) begin : gen_rows
    always_ff @(posedge clk_i) begin
      if (clear_i) begin
        buffer_q[r] <= '0;
      end else if (write_en_i && (write_addr_i == x_row_addr_t'(r))) begin
        buffer_q[r] <= wdata_i;
      end
    end

    assign rdata_o[r] = buffer_q[r][read_addr_q];  // Same column taken from every row.
  end

endmodule : x_transpose_scm

/* source/x_buffer_ctrl.sv */
/*
 * Operand-X buffer load/drain sequencer.
 * Latches the tile size on start and clears the datapath, counts row writes
 * during load, then steps the column reads during drain and flags the end.
 */

`timescale 1ns/10ps

module x_buffer_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      start_i,
  input  x_buffer_pkg::x_tile_cfg_t cfg_i,
  input  logic                      row_valid_i,
  output logic                      clear_o,
  output logic                      load_en_o,
  output x_buffer_pkg::x_tile_cfg_t cfg_o,
  output logic                      write_en_o,
  output x_buffer_pkg::x_row_addr_t write_addr_o,
  output logic                      read_en_o,
  output x_buffer_pkg::x_col_addr_t read_addr_o,
  output logic                      busy_o,
  output logic                      col_valid_o,
  output logic                      done_o
);
  import x_buffer_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    LOAD,
    DRAIN
  } state_e;

  state_e          state_q;
  x_tile_cfg_t     cfg_q;
  x_row_addr_t     row_cnt_q;
  x_col_addr_t     col_cnt_q;
  logic            busy_q;
  logic            col_valid_q;
  logic            done_q;
  logic            accept;
  logic            is_last_row;
  logic            is_last_col;
  logic [ROW_AW:0] last_row_idx;
  logic [COL_AW:0] last_col_idx;

  // Busy stays high through the done cycle, so a start there is dropped.
  assign accept = start_i & ~busy_q;

  assign last_row_idx = cfg_q.n_rows - 1'b1;
  assign last_col_idx = cfg_q.n_cols - 1'b1;
  assign is_last_row  = ({1'b0, row_cnt_q} == last_row_idx);
  assign is_last_col  = ({1'b0, col_cnt_q} == last_col_idx);

  assign clear_o      = accept;  // Datapath clears on the same edge that latches cfg.
  assign load_en_o    = (state_q == LOAD);
  assign cfg_o        = cfg_q;
  assign write_en_o   = row_valid_i & (state_q == LOAD);
  assign write_addr_o = row_cnt_q;
  assign read_en_o    = (state_q == DRAIN);
  assign read_addr_o  = col_cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      cfg_q     <= '0;
      row_cnt_q <= '0;
      col_cnt_q <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (accept) begin
            state_q   <= LOAD;
            cfg_q     <= cfg_i;
            row_cnt_q <= '0;
            col_cnt_q <= '0;
          end
        end
        LOAD: begin
          if (write_en_o) begin
            if (is_last_row) begin
              state_q   <= DRAIN;  // Drain begins right after the last row lands.
              row_cnt_q <= '0;
            end else begin
              row_cnt_q <= row_cnt_q + 1'b1;
            end
          end
        end
        DRAIN: begin
          if (is_last_col) begin
            state_q   <= IDLE;
            col_cnt_q <= '0;
          end else begin
            col_cnt_q <= col_cnt_q + 1'b1;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Column strobes trail the reads by one cycle to line up with rdata.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q      <= 1'b0;
      col_valid_q <= 1'b0;
      done_q      <= 1'b0;
    end else begin
      col_valid_q <= read_en_o;
      done_q      <= read_en_o & is_last_col;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (done_q) begin
        busy_q <= 1'b0;
      end
    end
  end

  assign busy_o      = busy_q;
  assign col_valid_o = col_valid_q;
  assign done_o      = done_q;

endmodule : x_buffer_ctrl

/* source/x_buffer_top.sv */
/*
 * Operand-X transpose buffer.
 * Loads a tile row by row from a word stream and plays it out column by
 * column, with rows and columns outside the tile's real size read as zero.
 */

`timescale 1ns/10ps

module x_buffer_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      start_i,
  input  x_buffer_pkg::x_tile_cfg_t cfg_i,
  input  logic                      word_valid_i,
  input  x_buffer_pkg::x_word_t     word_i,
  output logic                      busy_o,
  output logic                      col_valid_o,
  output x_buffer_pkg::x_col_t      col_o,
  output logic                      done_o
);
  import x_buffer_pkg::*;

  logic        clear;
  logic        load_en;
  x_tile_cfg_t cfg_q;
  logic        row_valid;
  x_row_t      row_data;
  logic        write_en;
  x_row_addr_t write_addr;
  logic        read_en;
  x_col_addr_t read_addr;

  x_buffer_ctrl u_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start_i),
    .cfg_i        (cfg_i),
    .row_valid_i  (row_valid),
    .clear_o      (clear),
    .load_en_o    (load_en),
    .cfg_o        (cfg_q),
    .write_en_o   (write_en),
    .write_addr_o (write_addr),
    .read_en_o    (read_en),
    .read_addr_o  (read_addr),
    .busy_o       (busy_o),
    .col_valid_o  (col_valid_o),
    .done_o       (done_o)
  );

  x_row_packer u_packer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (clear),
    .load_en_i    (load_en),
    .cfg_i        (cfg_q),
    .word_valid_i (word_valid_i),
    .word_i       (word_i),
    .row_valid_o  (row_valid),
    .row_o        (row_data)
  );

  x_transpose_scm u_scm (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (clear),
    .write_en_i   (write_en),
    .write_addr_i (write_addr),
    .wdata_i      (row_data),
    .read_en_i    (read_en),
    .read_addr_i  (read_addr),
    .rdata_o      (col_o)
  );

endmodule : x_buffer_top

/* dv/tb_x_buffer.sv */
/*
 * Testbench for the operand-X transpose buffer.
 * Loads directed tiles of random words and checks every column that leaves
 * against a transpose model of the loaded tile.
 */

`timescale 1ns/10ps

module tb_x_buffer;
  import x_buffer_pkg::*;

  typedef logic [$bits(x_col_t)-1:0] check_t;

  localparam int TIMEOUT = 200;

  logic        clk_i;
  logic        rst_ni;
  logic        start_i;
  x_tile_cfg_t cfg_i;
  logic        word_valid_i;
  x_word_t     word_i;
  logic        busy_o;
  logic        col_valid_o;
  x_col_t      col_o;
  logic        done_o;

  integer      seed;
  x_word_t     tile_words [NUM_ROWS][NUM_COLS];  // Words of the tile in flight.

  x_buffer_top u_dut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start_i),
    .cfg_i        (cfg_i),
    .word_valid_i (word_valid_i),
    .word_i       (word_i),
    .busy_o       (busy_o),
    .col_valid_o  (col_valid_o),
    .col_o        (col_o),
    .done_o       (done_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic check_value(input string name, input check_t expected, input check_t actual);
    if (expected !== actual) begin
      $display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
      $display("Regression failed");
      $fatal(1, "Value mismatch in %s", name);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout: %s", what);
    $display("Regression failed");
    $fatal(1, "Timeout waiting for %s", what);
  endtask

  // Column c of the transposed tile. Zero outside the tile's real size.
  function automatic x_col_t model_col(input int c, input int nr, input int nc);
    x_col_t col;
    col = '0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      if (r < nr && c < nc) begin
        col[r] = tile_words[r][c];
      end
    end
    return col;
  endfunction

  task automatic start_tile(input int nr, input int nc);
    @(negedge clk_i);
    start_i      = 1'b1;
    cfg_i.n_rows = nr[ROW_AW:0];
    cfg_i.n_cols = nc[COL_AW:0];
    @(negedge clk_i);
    start_i = 1'b0;
  endtask

  // With busy_start set, a start with another size rides on the first word.
  task automatic load_words(input int nr, input int nc, input bit busy_start);
    if (busy_start) begin
      cfg_i = '1;
    end
    for (int r = 0; r < nr; r++) begin
      for (int c = 0; c < nc; c++) begin
        tile_words[r][c] = x_word_t'($random(seed));
        word_valid_i     = 1'b1;
        word_i           = tile_words[r][c];
        start_i          = busy_start && (r == 0) && (c == 0);
        @(negedge clk_i);
      end
    end
    word_valid_i = 1'b0;
    start_i      = 1'b0;
  endtask

  // Noise drives stray words and starts while the columns leave.
  task automatic collect_columns(input string name, input int nr, input int nc, input bit noise);
    int wait_cnt;
    wait_cnt = 0;
    while (!col_valid_o && wait_cnt < TIMEOUT) begin
      wait_cnt++;
      @(negedge clk_i);
    end
    if (!col_valid_o) begin
      report_timeout({name, ": col_valid_o never rose"});
    end
    for (int c = 0; c < nc; c++) begin
      check_value({name, " col_valid_o"}, check_t'(1'b1), check_t'(col_valid_o));
      check_value({name, " col_o"}, check_t'(model_col(c, nr, nc)), check_t'(col_o));
      check_value({name, " done_o"}, check_t'(c == nc - 1), check_t'(done_o));
      word_valid_i = noise;
      word_i       = x_word_t'($random(seed));
      start_i      = noise;
      @(negedge clk_i);
    end
    word_valid_i = 1'b0;
    start_i      = 1'b0;
    check_value({name, " col_valid_o after drain"}, '0, check_t'(col_valid_o));
    check_value({name, " done_o after drain"}, '0, check_t'(done_o));
    wait_cnt = 0;
    while (busy_o && wait_cnt < TIMEOUT) begin
      wait_cnt++;
      @(negedge clk_i);
    end
    if (busy_o) begin
      report_timeout({name, ": busy_o never fell after done_o"});
    end
  endtask

  task automatic run_tile(input string name, input int nr, input int nc, input bit noise);
    start_tile(nr, nc);
    check_value({name, " busy_o after start"}, check_t'(1'b1), check_t'(busy_o));
    load_words(nr, nc, noise);
    collect_columns(name, nr, nc, noise);
  endtask

  task automatic full_tile();
    run_tile("full_tile", NUM_ROWS, NUM_COLS, 1'b0);
  endtask

  task automatic partial_tile();
    run_tile("partial_tile 3x5", 3, 5, 1'b0);
    run_tile("partial_tile 2x7", 2, 7, 1'b0);
    run_tile("partial_tile 1x1", 1, 1, 1'b0);
  endtask

  // A short tile after a full one must not see the old rows.
  task automatic clear_between_tiles();
    run_tile("clear_between_tiles full", NUM_ROWS, NUM_COLS, 1'b0);
    run_tile("clear_between_tiles 1x3", 1, 3, 1'b0);
  endtask

  task automatic ignored_inputs();
    for (int i = 0; i < 4; i++) begin
      @(negedge clk_i);
      word_valid_i = 1'b1;
      word_i       = x_word_t'($random(seed));
    end
    @(negedge clk_i);
    word_valid_i = 1'b0;
    run_tile("ignored_inputs noisy", 2, 6, 1'b1);
    run_tile("ignored_inputs next", NUM_ROWS, 3, 1'b0);
  endtask

  task automatic contiguous_drain();
    check_value("contiguous_drain busy_o idle", '0, check_t'(busy_o));
    run_tile("contiguous_drain 4x1", NUM_ROWS, 1, 1'b0);
    run_tile("contiguous_drain 1x8", 1, NUM_COLS, 1'b0);
  endtask

  initial begin
    seed         = 32'he4fb_56a8;
    rst_ni       = 1'b0;
    start_i      = 1'b0;
    cfg_i        = '0;
    word_valid_i = 1'b0;
    word_i       = '0;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    check_value("reset busy_o", '0, check_t'(busy_o));
    check_value("reset col_valid_o", '0, check_t'(col_valid_o));
    check_value("reset done_o", '0, check_t'(done_o));
    full_tile();
    partial_tile();
    clear_between_tiles();
    ignored_inputs();
    contiguous_drain();
    $display("Regression passed");
    $finish;
  end

endmodule : tb_x_buffer

/* files.f */
+incdir+include
source/x_buffer_pkg.sv
source/x_row_packer.sv
source/x_transpose_scm.sv
source/x_buffer_ctrl.sv
source/x_buffer_top.sv
dv/tb_x_buffer.sv

/* Makefile */
# Verilator flow for the operand-X transpose buffer.

VERILATOR  ?= verilator
FILELIST   ?= files.f
TB_TOP     ?= tb_x_buffer
RTL_TOP    ?= x_buffer_top
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing
PASS_MSG   ?= Regression passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# The run passes only if the simulation output holds the pass message.
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
